/* all.f */
source/amo_pkg.sv
source/mem_if.sv
source/apb_cmd_slave.sv
source/lrsc.sv
source/amo_core.sv
source/data_mem.sv
source/amo_top.sv
dv/amo_checker.sv
dv/tb_amo_top.sv

/* dv/amo_checker.sv */
module amo_checker (
    input logic                       clk,
    input logic                       reset_n,
    input logic                       read_en_i,
    input logic                       write_en_i,
    input logic [amo_pkg::DATA_W-1:0] addr_i,
    input logic [amo_pkg::DATA_W-1:0] wdata_i,
    input logic                       stall_i,
    input logic                       done_i
);

    logic assert_failed = 1'b0;

    // one request kind at a time on the memory link.
    no_dual_req_a: assert property (@(posedge clk) disable iff (!reset_n)
        !(read_en_i && write_en_i))
        else begin
            $error("memory read and write requested in the same cycle");
            assert_failed = 1'b1;
        end

    // a stalled request is held until accepted.
    stable_req_a: assert property (@(posedge clk) disable iff (!reset_n)
        stall_i |=> $stable(read_en_i) && $stable(write_en_i)
                    && $stable(addr_i) && $stable(wdata_i))
        else begin
            $error("memory request changed while stall was high");
            assert_failed = 1'b1;
        end

    done_pulse_a: assert property (@(posedge clk) disable iff (!reset_n)
        done_i |=> !done_i)
        else begin
            $error("done held high for more than one cycle");
            assert_failed = 1'b1;
        end

endmodule

bind amo_core amo_checker u_checker (
    .clk        (clk),
    .reset_n    (reset_n),
    .read_en_i  (mem.read_en),
    .write_en_i (mem.write_en),
    .addr_i     (mem.addr),
    .wdata_i    (mem.wdata),
    .stall_i    (mem.stall),
    .done_i     (done_o)
);

/* dv/tb_amo_top.sv */
module tb_amo_top;

    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DLY   = 5;
    localparam int MEM_DEPTH   = 64;
    localparam int MEM_WAIT    = 2;
    localparam int NUM_CMDS    = 39; // commands issued over all tests.
    localparam int READY_LIMIT = (MEM_WAIT + 1) * 8;
    localparam int WDOG_CYCLES = NUM_CMDS * (MEM_WAIT + 1) * 8 + 200;

    logic        clk;
    logic        reset_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [4:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;

    logic [31:0] lfsr_q = 32'ha2c3;
    logic [31:0] model_mem [MEM_DEPTH];

    amo_top #(
        .MEM_DEPTH (MEM_DEPTH),
        .MEM_WAIT  (MEM_WAIT)
    ) u_dut (
        .clk       (clk),
        .reset_n   (reset_n),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        string line;
        if (actual !== expected) begin
            line = $sformatf("error: time %0t, signal %s, expected %h, actual %h",
                             $time, name, expected, actual);
            abort_run(line);
        end
    endtask

    // fibonacci lfsr with taps 32 22 2 1.
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], lfsr_step()};
        return v;
    endfunction

    function automatic logic [31:0] rand_addr();
        logic [31:0] bits;
        bits = rand_bits(6);
        return {24'h0, bits[5:0], 2'b00}; // word aligned inside the memory.
    endfunction

    function automatic int word_idx(input logic [31:0] addr);
        return (addr >> 2) % MEM_DEPTH;
    endfunction

    task automatic apply_reset();
        reset_n = 1'b0;
        foreach (model_mem[i])
            model_mem[i] = '0; // memory clears on reset.
        repeat (10) @(posedge clk);
        #DRIVE_DLY;
        reset_n = 1'b1;
    endtask

    // returns on the falling edge where pready is high.
    task automatic wait_ready();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!pready) begin
            waited++;
            if (waited > READY_LIMIT)
                abort_run("pready stayed low, command back-pressure was never released");
            @(negedge clk);
        end
    endtask

    task automatic apb_write(input logic [4:0] addr, input logic [31:0] data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #DRIVE_DLY;
        penable = 1'b1;
        wait_ready();
        @(posedge clk);
        #DRIVE_DLY;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [4:0] addr, output logic [31:0] data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #DRIVE_DLY;
        penable = 1'b1;
        wait_ready();
        data = prdata;
        @(posedge clk);
        #DRIVE_DLY;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic run_cmd(input amo_pkg::amo_op_t op, input logic [31:0] addr,
                           input logic [31:0] wdata);
        apb_write(amo_pkg::REG_ADDR, addr);
        apb_write(amo_pkg::REG_WDATA, wdata);
        apb_write(amo_pkg::REG_CMD, {30'h0, op});
    endtask

    task automatic check_word(input logic [31:0] addr);
        logic [31:0] got;
        run_cmd(amo_pkg::OP_LW, addr, '0);
        apb_read(amo_pkg::REG_RDATA, got);
        check_eq($sformatf("rdata[%h]", addr), model_mem[word_idx(addr)], got);
    endtask

    task automatic check_status(input logic exp_fail, input logic exp_res);
        logic [31:0] st;
        apb_read(amo_pkg::REG_STATUS, st);
        check_eq("status.sc_fail", {31'h0, exp_fail}, {31'h0, st[amo_pkg::STAT_SC_FAIL]});
        check_eq("status.res_valid", {31'h0, exp_res}, {31'h0, st[amo_pkg::STAT_RES_VALID]});
    endtask

    task automatic test_store_load();
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] addrs [$];
        for (int i = 0; i < 4; i++)
            check_word(rand_addr()); // nothing written yet so it reads zero.
        for (int i = 0; i < 8; i++) begin
            addr = rand_addr();
            data = rand_bits(32);
            run_cmd(amo_pkg::OP_SW, addr, data);
            model_mem[word_idx(addr)] = data;
            addrs.push_back(addr);
        end
        foreach (addrs[i])
            check_word(addrs[i]);
    endtask

    task automatic test_lr_sc_pass();
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] got;
        addr = rand_addr();
        data = rand_bits(32);
        run_cmd(amo_pkg::OP_LR, addr, '0);
        apb_read(amo_pkg::REG_RDATA, got);
        check_eq("lr rdata", model_mem[word_idx(addr)], got);
        check_status(1'b0, 1'b1);
        run_cmd(amo_pkg::OP_SC, addr, data);
        check_status(1'b0, 1'b0);
        model_mem[word_idx(addr)] = data;
        check_word(addr);
    endtask

    task automatic test_sc_other_addr();
        logic [31:0] addr_a;
        logic [31:0] addr_b;
        logic [31:0] data;
        addr_a = rand_addr();
        addr_b = (addr_a + 32'd4) & 32'hfc;
        data   = rand_bits(32); // same word at both so only the address differs.
        run_cmd(amo_pkg::OP_SW, addr_a, data);
        model_mem[word_idx(addr_a)] = data;
        run_cmd(amo_pkg::OP_SW, addr_b, data);
        model_mem[word_idx(addr_b)] = data;
        run_cmd(amo_pkg::OP_LR, addr_a, '0);
        run_cmd(amo_pkg::OP_SC, addr_b, ~data);
        check_status(1'b1, 1'b0);
        check_word(addr_a);
        check_word(addr_b);
    endtask

    task automatic test_sc_after_store();
        logic [31:0] addr;
        logic [31:0] sw_data;
        logic [31:0] sc_data;
        addr    = rand_addr();
        sw_data = ~model_mem[word_idx(addr)]; // differs from what lr sees.
        sc_data = rand_bits(32);
        if (sc_data == sw_data)
            sc_data = ~sc_data;
        run_cmd(amo_pkg::OP_LR, addr, '0);
        run_cmd(amo_pkg::OP_SW, addr, sw_data);
        model_mem[word_idx(addr)] = sw_data;
        run_cmd(amo_pkg::OP_SC, addr, sc_data);
        check_status(1'b1, 1'b0);
        check_word(addr);
    endtask

    task automatic test_sc_no_reservation();
        logic [31:0] addr;
        logic [31:0] data;
        addr = rand_addr();
        data = model_mem[word_idx(addr)];
        run_cmd(amo_pkg::OP_LR, addr, '0);
        run_cmd(amo_pkg::OP_SC, addr, data); // succeeds and leaves the word as it was.
        check_status(1'b0, 1'b0);
        run_cmd(amo_pkg::OP_SC, addr, ~data); // address and word still match the old lr.
        check_status(1'b1, 1'b0);
        check_word(addr);
        apply_reset();
        addr = rand_addr();
        run_cmd(amo_pkg::OP_SC, addr, ~model_mem[word_idx(addr)]);
        check_status(1'b1, 1'b0);
        check_word(addr);
    endtask

    initial begin
        #(WDOG_CYCLES * CLK_PERIOD);
        abort_run("watchdog timeout, the run hung waiting on the DUT");
    end

    initial begin
        wait (u_dut.u_core.u_checker.assert_failed === 1'b1);
        abort_run("an assertion on the memory link or the done pulse failed");
    end

    initial begin
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        apply_reset();
        test_store_load();
        test_lr_sc_pass();
        test_sc_other_addr();
        test_sc_after_store();
        test_sc_no_reservation();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* source/amo_core.sv */
module amo_core (
    input  logic                       clk,
    input  logic                       reset_n,

    input  logic                       cmd_valid_i,
    input  amo_pkg::amo_op_t           cmd_op_i,
    input  logic [amo_pkg::DATA_W-1:0] cmd_addr_i,
    input  logic [amo_pkg::DATA_W-1:0] cmd_wdata_i,

    output logic                       done_o,
    output logic [amo_pkg::DATA_W-1:0] rdata_o,
    output logic                       sc_fail_o,
    output logic                       res_valid_o,

    mem_if.core                        mem
);

    typedef enum logic [1:0] {
        C_IDLE,
        C_ACCESS,
        C_RDATA,
        C_SC
    } core_state_t;

    core_state_t                state_q;
    amo_pkg::amo_op_t           op_q;
    logic [amo_pkg::DATA_W-1:0] addr_q;
    logic [amo_pkg::DATA_W-1:0] wdata_q;
    logic [amo_pkg::DATA_W-1:0] res_addr_q;
    logic [amo_pkg::DATA_W-1:0] res_data_q;
    logic                       res_valid_q;

    logic                       sc_en;
    logic                       sc_done;
    logic                       plain_rd;
    logic                       plain_wr;
    logic                       eq_result;
    logic                       lrsc_hold;
    logic                       lrsc_rd;
    logic                       lrsc_wr;
    logic                       lrsc_fail;
    logic [amo_pkg::DATA_W-1:0] cmp_a;
    logic [amo_pkg::DATA_W-1:0] cmp_b;

    assign sc_en    = (state_q == C_SC);
    assign plain_rd = (state_q == C_ACCESS) && (op_q != amo_pkg::OP_SW);
    assign plain_wr = (state_q == C_ACCESS) && (op_q == amo_pkg::OP_SW);
    assign sc_done  = sc_en && !lrsc_hold && !mem.stall; // leaving STORE.

    // no valid reservation never matches.
    assign eq_result = res_valid_q && (cmp_a == cmp_b);

    assign mem.read_en  = sc_en ? lrsc_rd : plain_rd;
    assign mem.write_en = sc_en ? lrsc_wr : plain_wr;
    assign mem.addr     = addr_q;
    assign mem.wdata    = wdata_q;

    lrsc u_lrsc (
        .clk                (clk),
        .reset_n            (reset_n),
        .stall_i            (mem.stall),
        .enable_i           (sc_en),
        .eq_result_i        (eq_result),
        .rs1_data_i         (addr_q),
        .data_i             (mem.rdata),
        .reservation_addr_i (res_addr_q),
        .reservation_data_i (res_data_q),
        .hold_o             (lrsc_hold),
        .mem_read_enable_o  (lrsc_rd),
        .mem_write_enable_o (lrsc_wr),
        .result_o           (lrsc_fail),
        .cmp_opA_o          (cmp_a),
        .cmp_opB_o          (cmp_b)
    );

    always_ff @(posedge clk) begin
        if ((state_q == C_IDLE) && cmd_valid_i) begin
            addr_q  <= cmd_addr_i;
            wdata_q <= cmd_wdata_i;
        end
        if (state_q == C_RDATA) begin
            rdata_o <= mem.rdata;
            if (op_q == amo_pkg::OP_LR) begin
                res_addr_q <= addr_q;
                res_data_q <= mem.rdata; // value seen by lr.
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q     <= C_IDLE;
            op_q        <= amo_pkg::OP_LW;
            done_o      <= 1'b0;
            sc_fail_o   <= 1'b0;
            res_valid_q <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                C_IDLE: if (cmd_valid_i) begin
                    op_q    <= cmd_op_i;
                    state_q <= (cmd_op_i == amo_pkg::OP_SC) ? C_SC : C_ACCESS;
                end
                C_ACCESS: if (!mem.stall) begin
                    if (op_q == amo_pkg::OP_SW) begin
                        done_o    <= 1'b1;
                        sc_fail_o <= 1'b0;
                        state_q   <= C_IDLE;
                    end else begin
                        state_q <= C_RDATA;
                    end
                end
                C_RDATA: begin
                    done_o    <= 1'b1;
                    sc_fail_o <= 1'b0;
                    state_q   <= C_IDLE;
                    if (op_q == amo_pkg::OP_LR)
                        res_valid_q <= 1'b1;
                end
                default: if (sc_done) begin
                    done_o      <= 1'b1;
                    sc_fail_o   <= lrsc_fail;
                    res_valid_q <= 1'b0; // sc always drops the reservation.
                    state_q     <= C_IDLE;
                end
            endcase
        end
    end

    assign res_valid_o = res_valid_q;

endmodule

/* source/amo_pkg.sv */
package amo_pkg;

    // data and address width of the core.
    localparam int DATA_W = 32;

    // command opcodes written to the command register.
    typedef enum logic [1:0] {
        OP_LW = 2'd0,
        OP_SW = 2'd1,
        OP_LR = 2'd2,
        OP_SC = 2'd3
    } amo_op_t;

    // apb byte offsets.
    localparam logic [4:0] REG_ADDR   = 5'h00;
    localparam logic [4:0] REG_WDATA  = 5'h04;
    localparam logic [4:0] REG_CMD    = 5'h08;
    localparam logic [4:0] REG_RDATA  = 5'h0C;
    localparam logic [4:0] REG_STATUS = 5'h10;

    // status register bits.
    localparam int STAT_SC_FAIL   = 0;
    localparam int STAT_RES_VALID = 1;

endpackage

/* source/amo_top.sv */
module amo_top #(
    parameter int MEM_DEPTH = 64,
    parameter int MEM_WAIT  = 1
) (
    input  logic                       clk,
    input  logic                       reset_n,

    input  logic                       psel_i,
    input  logic                       penable_i,
    input  logic                       pwrite_i,
    input  logic [4:0]                 paddr_i,
    input  logic [amo_pkg::DATA_W-1:0] pwdata_i,
    output logic [amo_pkg::DATA_W-1:0] prdata_o,
    output logic                       pready_o
);

    logic                       cmd_valid;
    amo_pkg::amo_op_t           cmd_op;
    logic [amo_pkg::DATA_W-1:0] cmd_addr;
    logic [amo_pkg::DATA_W-1:0] cmd_wdata;
    logic                       done;
    logic [amo_pkg::DATA_W-1:0] rdata;
    logic                       sc_fail;
    logic                       res_valid;

    mem_if mem_bus ();

    // host side.
    apb_cmd_slave u_slave (
        .clk         (clk),
        .reset_n     (reset_n),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .cmd_valid_o (cmd_valid),
        .cmd_op_o    (cmd_op),
        .cmd_addr_o  (cmd_addr),
        .cmd_wdata_o (cmd_wdata),
        .done_i      (done),
        .rdata_i     (rdata),
        .sc_fail_i   (sc_fail),
        .res_valid_i (res_valid)
    );

    amo_core u_core (
        .clk         (clk),
        .reset_n     (reset_n),
        .cmd_valid_i (cmd_valid),
        .cmd_op_i    (cmd_op),
        .cmd_addr_i  (cmd_addr),
        .cmd_wdata_i (cmd_wdata),
        .done_o      (done),
        .rdata_o     (rdata),
        .sc_fail_o   (sc_fail),
        .res_valid_o (res_valid),
        .mem         (mem_bus.core)
    );

    data_mem #(
        .MEM_DEPTH (MEM_DEPTH),
        .MEM_WAIT  (MEM_WAIT)
    ) u_mem (
        .clk     (clk),
        .reset_n (reset_n),
        .mem     (mem_bus.memory)
    );

endmodule

/* source/apb_cmd_slave.sv */
module apb_cmd_slave (
    input  logic                       clk,
    input  logic                       reset_n,

    input  logic                       psel_i,
    input  logic                       penable_i,
    input  logic                       pwrite_i,
    input  logic [4:0]                 paddr_i,
    input  logic [amo_pkg::DATA_W-1:0] pwdata_i,
    output logic [amo_pkg::DATA_W-1:0] prdata_o,
    output logic                       pready_o,

    output logic                       cmd_valid_o,
    output amo_pkg::amo_op_t           cmd_op_o,
    output logic [amo_pkg::DATA_W-1:0] cmd_addr_o,
    output logic [amo_pkg::DATA_W-1:0] cmd_wdata_o,

    input  logic                       done_i,
    input  logic [amo_pkg::DATA_W-1:0] rdata_i,
    input  logic                       sc_fail_i,
    input  logic                       res_valid_i
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT,
        S_DONE
    } slv_state_t;

    slv_state_t                 state_q;
    logic                       access;
    logic                       cmd_wr;
    logic [amo_pkg::DATA_W-1:0] addr_q;
    logic [amo_pkg::DATA_W-1:0] wdata_q;
    logic [amo_pkg::DATA_W-1:0] rdata_q;
    logic                       sc_fail_q;
    logic                       res_valid_q;
    logic [amo_pkg::DATA_W-1:0] status;

    assign access = psel_i && penable_i;
    assign cmd_wr = access && pwrite_i && (paddr_i == amo_pkg::REG_CMD);

    // command writes stall the host until the core reports done.
    assign pready_o = access && (!cmd_wr || (state_q == S_DONE));

    always_ff @(posedge clk) begin
        if (access && pwrite_i && (paddr_i == amo_pkg::REG_ADDR))
            addr_q <= pwdata_i;
        if (access && pwrite_i && (paddr_i == amo_pkg::REG_WDATA))
            wdata_q <= pwdata_i;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q     <= S_IDLE;
            cmd_valid_o <= 1'b0;
            cmd_op_o    <= amo_pkg::OP_LW;
            rdata_q     <= '0;
            sc_fail_q   <= 1'b0;
            res_valid_q <= 1'b0;
        end else begin
            cmd_valid_o <= 1'b0;
            case (state_q)
                S_IDLE: if (cmd_wr) begin
                    cmd_valid_o <= 1'b1;
                    cmd_op_o    <= amo_pkg::amo_op_t'(pwdata_i[1:0]);
                    state_q     <= S_WAIT;
                end
                S_WAIT: if (done_i) begin
                    rdata_q     <= rdata_i;
                    sc_fail_q   <= sc_fail_i;
                    res_valid_q <= res_valid_i;
                    state_q     <= S_DONE;
                end
                default: state_q <= S_IDLE; // transfer ends here.
            endcase
        end
    end

    assign cmd_addr_o  = addr_q;
    assign cmd_wdata_o = wdata_q;

    always_comb begin
        status                         = '0;
        status[amo_pkg::STAT_SC_FAIL]   = sc_fail_q;
        status[amo_pkg::STAT_RES_VALID] = res_valid_q;
    end

    always_comb begin
        prdata_o = '0;
        case (paddr_i)
            amo_pkg::REG_ADDR:   prdata_o = addr_q;
            amo_pkg::REG_WDATA:  prdata_o = wdata_q;
            amo_pkg::REG_CMD:    prdata_o[1:0] = cmd_op_o;
            amo_pkg::REG_RDATA:  prdata_o = rdata_q;
            amo_pkg::REG_STATUS: prdata_o = status;
            default:             prdata_o = '0;
        endcase
    end

endmodule

/* source/data_mem.sv */
module data_mem #(
    parameter int MEM_DEPTH = 64,
    parameter int MEM_WAIT  = 1
) (
    input  logic  clk,
    input  logic  reset_n,
    mem_if.memory mem
);

    localparam int IDX_W = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;
    localparam int CNT_W = (MEM_WAIT > 0) ? $clog2(MEM_WAIT + 1) : 1;
    localparam logic [CNT_W-1:0] WAIT_N = CNT_W'(MEM_WAIT);

    logic [amo_pkg::DATA_W-1:0] words_q [MEM_DEPTH];
    logic [CNT_W-1:0]           wait_q;
    logic [IDX_W-1:0]           idx;
    logic                       req;
    logic                       accept;

    assign req    = mem.read_en || mem.write_en;
    assign idx    = mem.addr[IDX_W+1:2]; // word index.
    assign accept = req && !mem.stall;

    // stall until MEM_WAIT cycles have passed for this request.
    assign mem.stall = req && (wait_q != WAIT_N);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            wait_q <= '0;
        else if (accept)
            wait_q <= '0;
        else if (req)
            wait_q <= wait_q + 1'b1;
    end

    // words start cleared.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < MEM_DEPTH; i++)
                words_q[i] <= '0;
        end else if (accept && mem.write_en) begin
            words_q[idx] <= mem.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && mem.read_en)
            mem.rdata <= words_q[idx];
    end

endmodule

/* source/lrsc.sv */
module lrsc (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       stall_i,
    input  logic                       enable_i,
    input  logic                       eq_result_i,

    input  logic [amo_pkg::DATA_W-1:0] rs1_data_i,
    input  logic [amo_pkg::DATA_W-1:0] data_i,
    input  logic [amo_pkg::DATA_W-1:0] reservation_addr_i,
    input  logic [amo_pkg::DATA_W-1:0] reservation_data_i,

    output logic                       hold_o,
    output logic                       mem_read_enable_o,
    output logic                       mem_write_enable_o,
    output logic                       result_o,
    output logic [amo_pkg::DATA_W-1:0] cmp_opA_o,
    output logic [amo_pkg::DATA_W-1:0] cmp_opB_o
);

    // one-hot sc sequence.
    typedef enum logic [3:0] {
        LOAD     = 4'b0001,
        CMP_ADDR = 4'b0010,
        CMP_DATA = 4'b0100,
        STORE    = 4'b1000
    } sc_state_t;

    sc_state_t state_q;
    sc_state_t state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            LOAD:     if (enable_i) state_d = CMP_ADDR;
            CMP_ADDR: state_d = eq_result_i ? CMP_DATA : STORE; // skip data on addr miss.
            CMP_DATA: state_d = STORE;
            default:  state_d = LOAD;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            state_q <= LOAD;
        else if (!stall_i)
            state_q <= state_d;
    end

    // addresses are compared first, then the word against the lr value.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cmp_opA_o <= '0;
            cmp_opB_o <= '0;
        end else if (!stall_i) begin
            if (state_q == LOAD) begin
                cmp_opA_o <= rs1_data_i;
                cmp_opB_o <= reservation_addr_i;
            end else if (state_q == CMP_ADDR) begin
                cmp_opA_o <= data_i;
                cmp_opB_o <= reservation_data_i;
            end
        end
    end

    // failure flag.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            result_o <= 1'b0;
        else if (!stall_i)
            result_o <= ~eq_result_i;
    end

    assign hold_o             = enable_i && (state_q != STORE);
    assign mem_read_enable_o  = enable_i && (state_q == LOAD);
    assign mem_write_enable_o = (state_q == STORE) && !result_o;

endmodule

/* source/mem_if.sv */
interface mem_if;

    logic                        read_en;
    logic                        write_en;
    logic [amo_pkg::DATA_W-1:0]  addr;
    logic [amo_pkg::DATA_W-1:0]  wdata;
    logic [amo_pkg::DATA_W-1:0]  rdata; // valid the cycle after a read is accepted.
    logic                        stall;

    modport core (
        output read_en,
        output write_en,
        output addr,
        output wdata,
        input  rdata,
        input  stall
    );

    modport memory (
        input  read_en,
        input  write_en,
        input  addr,
        input  wdata,
        output rdata,
        output stall
    );

endinterface
